//--- logic/loader_pkg.sv
//--------------------------------------------------------------------------
// Memory loader shared definitions
// Word and address types, flash opcode, boot image layout and the
// SPI clock divider used by the flash reader
//--------------------------------------------------------------------------
`default_nettype none

package loader_pkg;

  // One RAM word and its word address
  typedef logic [31:0] data_t;
  typedef logic [23:0] word_addr_t;

  // Flash side
  typedef logic [23:0] flash_addr_t;
  typedef logic [7:0]  byte_t;

  // Number of image pages
  typedef logic [15:0] page_count_t;

  //--------------------------------------------------------------------------
  // Flash opcodes and image layout
  //--------------------------------------------------------------------------
  localparam logic [7:0]  FLASH_READ      = 8'h03;
  localparam logic [15:0] BOOT_FIRST_PAGE = 16'h0800;
  localparam int          PAGE_BYTES      = 256;
  localparam int          PAGE_WORDS      = 64;

  // clk cycles per SPI clock half
  localparam int          SPI_HALF_PERIOD = 1;

endpackage

`default_nettype wire

//--- logic/wb_if.sv
//--------------------------------------------------------------------------
// Wishbone classic bus
// Single transfer per cycle frame, word addressed
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

interface wb_if;

  logic                   cyc;
  logic                   stb;
  logic                   we;
  loader_pkg::word_addr_t adr;
  loader_pkg::data_t      dat_w;
  loader_pkg::data_t      dat_r;
  logic                   ack;

  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );

endinterface

`default_nettype wire

//--- logic/flash_read_if.sv
//--------------------------------------------------------------------------
// Flash read request and byte stream
// Start pulse with address and length, bytes returned over valid/ready
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

interface flash_read_if;

  logic                    start;
  loader_pkg::flash_addr_t addr;
  loader_pkg::flash_addr_t len;
  loader_pkg::byte_t       rd_byte;
  logic                    byte_valid;
  logic                    byte_ready;
  logic                    busy;

  modport master (
    output start, addr, len, byte_ready,
    input  rd_byte, byte_valid, busy
  );

  modport slave (
    input  start, addr, len, byte_ready,
    output rd_byte, byte_valid, busy
  );

endinterface

`default_nettype wire

//--- logic/spi_flash_reader.sv
//--------------------------------------------------------------------------
// SPI flash reader
// Sends READ with a 24-bit address, then shifts in len bytes MSB first
// and hands them out one at a time. The SPI clock is held low while a
// finished byte waits to be taken
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module spi_flash_reader (
  input  wire          clk,
  input  wire          reset_in,
  flash_read_if.slave  rd,
  output logic         flash_sclk,
  output logic         flash_cs_n,
  output logic         flash_mosi,
  input  wire          flash_miso
);

  typedef enum logic [1:0] {ST_IDLE, ST_CMD, ST_DATA, ST_DONE} state_t;

  state_t                  state;
  logic [$clog2(loader_pkg::SPI_HALF_PERIOD + 1)-1:0] half_cnt;
  logic [4:0]              bit_cnt;
  loader_pkg::flash_addr_t byte_cnt;
  loader_pkg::flash_addr_t len_q;
  logic [31:0]             cmd_sr;
  loader_pkg::byte_t       in_sr;
  logic                    running;
  logic                    tick;
  logic                    stall;

  assign running = (state == ST_CMD) || (state == ST_DATA);
  assign tick    = running && (half_cnt == loader_pkg::SPI_HALF_PERIOD - 1);

  // Held byte not taken this cycle
  assign stall   = rd.byte_valid && !rd.byte_ready;

  // Idle low while deselected
  assign flash_mosi = !flash_cs_n && cmd_sr[31];

  //--------------------------------------------------------------------------
  // Control FSM and SPI clock
  //--------------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset_in) begin
    if (reset_in) begin
      state         <= ST_IDLE;
      half_cnt      <= '0;
      bit_cnt       <= '0;
      byte_cnt      <= '0;
      flash_sclk    <= 1'b0;
      flash_cs_n    <= 1'b1;
      rd.busy       <= 1'b0;
      rd.byte_valid <= 1'b0;
    end else begin
      if (rd.byte_valid && rd.byte_ready) begin
        rd.byte_valid <= 1'b0;
      end
      half_cnt <= (tick || !running) ? '0 : half_cnt + 1'b1;

      case (state)
        ST_IDLE: begin
          if (rd.start) begin
            state      <= ST_CMD;
            rd.busy    <= 1'b1;
            flash_cs_n <= 1'b0;
            bit_cnt    <= '0;
            byte_cnt   <= '0;
          end
        end
        ST_CMD, ST_DATA: begin
          if (tick) begin
            if (!flash_sclk) begin
              if (!stall) begin
                flash_sclk <= 1'b1;
              end
            end else begin
              // Falling edge ends one bit
              flash_sclk <= 1'b0;
              bit_cnt    <= bit_cnt + 5'd1;
              if (state == ST_CMD) begin
                if (bit_cnt == 5'd31) begin
                  state   <= ST_DATA;
                  bit_cnt <= '0;
                end
              end else if (bit_cnt[2:0] == 3'd7) begin
                rd.byte_valid <= 1'b1;
                byte_cnt      <= byte_cnt + 1'b1;
                if (byte_cnt == len_q - 1'b1) begin
                  state <= ST_DONE;
                end
              end
            end
          end
        end
        ST_DONE: begin
          // Release the flash once the last byte is taken
          if (!rd.byte_valid || rd.byte_ready) begin
            state      <= ST_IDLE;
            flash_cs_n <= 1'b1;
            rd.busy    <= 1'b0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  //--------------------------------------------------------------------------
  // Shift registers
  //--------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (state == ST_IDLE && rd.start) begin
      cmd_sr <= {loader_pkg::FLASH_READ, rd.addr};
      len_q  <= rd.len;
    end else if (tick && flash_sclk) begin
      // MOSI moves on the falling edge, MISO sampled while SCLK is high
      cmd_sr <= {cmd_sr[30:0], 1'b0};
      in_sr  <= {in_sr[6:0], flash_miso};
      if (state == ST_DATA && bit_cnt[2:0] == 3'd7) begin
        rd.rd_byte <= {in_sr[6:0], flash_miso};
      end
    end
  end

  // A new read is only requested while the reader is idle
  assert property (@(posedge clk) disable iff (reset_in) rd.start |-> !rd.busy);

endmodule

`default_nettype wire

//--- logic/boot_loader.sv
//--------------------------------------------------------------------------
// Boot loader
// Reads the image page by page from flash, packs bytes big-endian into
// words and writes them to RAM over Wishbone. The page count comes from
// the first word of page 0
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module boot_loader (
  input  wire          clk,
  input  wire          reset_in,
  flash_read_if.master rd,
  wb_if.master         wb,
  output logic         boot_done
);

  typedef enum logic [2:0] {ST_START, ST_BYTES, ST_WRITE, ST_NEXT, ST_DONE} state_t;

  state_t                                      state;
  loader_pkg::page_count_t                     page;
  loader_pkg::page_count_t                     page_total;
  loader_pkg::page_count_t                     hdr_count;
  logic [$clog2(loader_pkg::PAGE_WORDS)-1:0]   word_idx;
  logic [1:0]                                  byte_idx;
  loader_pkg::data_t                           word_buf;

  // Flash page address and RAM word address both follow the page counter
  assign rd.addr       = {loader_pkg::BOOT_FIRST_PAGE + page, 8'h00};
  assign rd.len        = loader_pkg::flash_addr_t'(loader_pkg::PAGE_BYTES);
  assign rd.byte_ready = (state == ST_BYTES);

  assign wb.we    = 1'b1;
  assign wb.adr   = loader_pkg::word_addr_t'({page, word_idx});
  assign wb.dat_w = word_buf;

  // Low half of the word being completed
  assign hdr_count = {word_buf[7:0], rd.rd_byte};

  always_ff @(posedge clk or posedge reset_in) begin
    if (reset_in) begin
      state      <= ST_START;
      page       <= '0;
      page_total <= '0;
      word_idx   <= '0;
      byte_idx   <= '0;
      rd.start   <= 1'b0;
      wb.cyc     <= 1'b0;
      wb.stb     <= 1'b0;
      boot_done  <= 1'b0;
    end else begin
      rd.start <= 1'b0;
      case (state)
        ST_START: begin
          if (!rd.busy) begin
            rd.start <= 1'b1;
            word_idx <= '0;
            byte_idx <= '0;
            state    <= ST_BYTES;
          end
        end
        ST_BYTES: begin
          if (rd.byte_valid) begin
            byte_idx <= byte_idx + 2'd1;
            if (byte_idx == 2'd3) begin
              wb.cyc <= 1'b1;
              wb.stb <= 1'b1;
              state  <= ST_WRITE;
              // Header word, zero means a single page
              if (page == '0 && word_idx == '0) begin
                page_total <= (hdr_count == '0) ? 16'd1 : hdr_count;
              end
            end
          end
        end
        ST_WRITE: begin
          if (wb.ack) begin
            wb.cyc   <= 1'b0;
            wb.stb   <= 1'b0;
            word_idx <= word_idx + 1'b1;
            state    <= (word_idx == loader_pkg::PAGE_WORDS - 1) ? ST_NEXT : ST_BYTES;
          end
        end
        ST_NEXT: begin
          if (page + 16'd1 == page_total) begin
            boot_done <= 1'b1;
            state     <= ST_DONE;
          end else begin
            page  <= page + 16'd1;
            state <= ST_START;
          end
        end
        ST_DONE: state <= ST_DONE;
        default: state <= ST_START;
      endcase
    end
  end

  // Big-endian packing, first byte ends up in the top lane
  always_ff @(posedge clk) begin
    if (state == ST_BYTES && rd.byte_valid) begin
      word_buf <= {word_buf[23:0], rd.rd_byte};
    end
  end

  // Write frame held with the same address and data until the slave acks
  assert property (@(posedge clk) disable iff (reset_in)
    wb.stb && !wb.ack |=> wb.stb && $stable(wb.adr) && $stable(wb.dat_w));

endmodule

`default_nettype wire

//--- logic/host_port.sv
//--------------------------------------------------------------------------
// Host access port
// Turns single read and write requests into one Wishbone frame each
// once the boot has finished
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module host_port (
  input  wire                         clk,
  input  wire                         reset_in,
  input  wire                         boot_done,
  input  wire                         write_req,
  input  wire                         read_req,
  input  wire loader_pkg::word_addr_t addr,
  input  wire loader_pkg::data_t      data_write,
  output loader_pkg::data_t           data_read,
  output logic                        read_valid,
  output logic                        busy,
  wb_if.master                        wb
);

  logic                   active;
  logic                   accept;
  logic                   we_q;
  loader_pkg::word_addr_t adr_q;
  loader_pkg::data_t      dat_q;

  assign busy   = active || !boot_done;
  assign accept = !busy && (write_req || read_req);

  assign wb.cyc   = active;
  assign wb.stb   = active;
  assign wb.we    = we_q;
  assign wb.adr   = adr_q;
  assign wb.dat_w = dat_q;

  always_ff @(posedge clk or posedge reset_in) begin
    if (reset_in) begin
      active     <= 1'b0;
      read_valid <= 1'b0;
    end else begin
      read_valid <= 1'b0;
      if (accept) begin
        active <= 1'b1;
      end else if (active && wb.ack) begin
        active     <= 1'b0;
        read_valid <= !we_q;
      end
    end
  end

  // Request latch, write has priority
  always_ff @(posedge clk) begin
    if (accept) begin
      we_q  <= write_req;
      adr_q <= addr;
      dat_q <= data_write;
    end
    if (active && wb.ack && !we_q) begin
      data_read <= wb.dat_r;
    end
  end

endmodule

`default_nettype wire

//--- logic/bus_arbiter.sv
//--------------------------------------------------------------------------
// Wishbone arbiter
// Two masters share one RAM slave. The grant is held for a whole frame
// and the boot loader wins when both open a frame together
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module bus_arbiter (
  input  wire  clk,
  input  wire  reset_in,
  wb_if.slave  m_boot,
  wb_if.slave  m_host,
  wb_if.master ram
);

  logic host_q;
  logic host_sel;
  logic locked;

  // Owner still has its frame open
  assign locked = host_q ? m_host.cyc : m_boot.cyc;

  always_comb begin
    if (locked) begin
      host_sel = host_q;
    end else if (m_boot.cyc) begin
      host_sel = 1'b0;
    end else if (m_host.cyc) begin
      host_sel = 1'b1;
    end else begin
      host_sel = host_q;
    end
  end

  always_ff @(posedge clk or posedge reset_in) begin
    if (reset_in) begin
      host_q <= 1'b0;
    end else begin
      host_q <= host_sel;
    end
  end

  //--------------------------------------------------------------------------
  // Request mux and response routing
  //--------------------------------------------------------------------------
  assign ram.cyc   = host_sel ? m_host.cyc   : m_boot.cyc;
  assign ram.stb   = host_sel ? m_host.stb   : m_boot.stb;
  assign ram.we    = host_sel ? m_host.we    : m_boot.we;
  assign ram.adr   = host_sel ? m_host.adr   : m_boot.adr;
  assign ram.dat_w = host_sel ? m_host.dat_w : m_boot.dat_w;

  assign m_boot.ack   = ram.ack && !host_sel;
  assign m_host.ack   = ram.ack && host_sel;
  assign m_boot.dat_r = host_sel ? '0 : ram.dat_r;
  assign m_host.dat_r = host_sel ? ram.dat_r : '0;

  // Ack only reaches a master with its own frame open
  assert property (@(posedge clk) disable iff (reset_in)
    (m_boot.ack |-> m_boot.cyc) and (m_host.ack |-> m_host.cyc));

  // No grant change inside an open frame
  assert property (@(posedge clk) disable iff (reset_in)
    ram.cyc && !ram.ack |=> $stable(host_sel));

endmodule

`default_nettype wire

//--- logic/memory_loader_top.sv
//--------------------------------------------------------------------------
// Memory loader top level
// Boot loader and host port share the RAM bus through the arbiter.
// The boot image comes from SPI flash
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module memory_loader_top (
  input  wire                         clk,
  input  wire                         reset_in,
  output wire                         boot_done,

  // Host side
  input  wire                         write_req,
  input  wire                         read_req,
  input  wire loader_pkg::word_addr_t addr,
  input  wire loader_pkg::data_t      data_write,
  output wire loader_pkg::data_t      data_read,
  output wire                         read_valid,
  output wire                         busy,

  // SPI flash
  output wire                         flash_sclk,
  output wire                         flash_cs_n,
  output wire                         flash_mosi,
  input  wire                         flash_miso,

  // RAM, Wishbone classic
  output wire                         ram_cyc,
  output wire                         ram_stb,
  output wire                         ram_we,
  output wire loader_pkg::word_addr_t ram_adr,
  output wire loader_pkg::data_t      ram_dat_w,
  input  wire loader_pkg::data_t      ram_dat_r,
  input  wire                         ram_ack
);

  wb_if         boot_bus ();
  wb_if         host_bus ();
  wb_if         ram_bus ();
  flash_read_if flash_rd ();

  spi_flash_reader u_reader (
    .clk        (clk),
    .reset_in   (reset_in),
    .rd         (flash_rd.slave),
    .flash_sclk (flash_sclk),
    .flash_cs_n (flash_cs_n),
    .flash_mosi (flash_mosi),
    .flash_miso (flash_miso)
  );

  boot_loader u_boot (
    .clk       (clk),
    .reset_in  (reset_in),
    .rd        (flash_rd.master),
    .wb        (boot_bus.master),
    .boot_done (boot_done)
  );

  host_port u_host (
    .clk        (clk),
    .reset_in   (reset_in),
    .boot_done  (boot_done),
    .write_req  (write_req),
    .read_req   (read_req),
    .addr       (addr),
    .data_write (data_write),
    .data_read  (data_read),
    .read_valid (read_valid),
    .busy       (busy),
    .wb         (host_bus.master)
  );

  bus_arbiter u_arb (
    .clk      (clk),
    .reset_in (reset_in),
    .m_boot   (boot_bus.slave),
    .m_host   (host_bus.slave),
    .ram      (ram_bus.master)
  );

  //--------------------------------------------------------------------------
  // RAM pins
  //--------------------------------------------------------------------------
  assign ram_cyc       = ram_bus.cyc;
  assign ram_stb       = ram_bus.stb;
  assign ram_we        = ram_bus.we;
  assign ram_adr       = ram_bus.adr;
  assign ram_dat_w     = ram_bus.dat_w;
  assign ram_bus.dat_r = ram_dat_r;
  assign ram_bus.ack   = ram_ack;

endmodule

`default_nettype wire

//--- tests/tb_models.sv
//--------------------------------------------------------------------------
// Testbench models
// SPI flash that answers READ commands from a byte image, and a
// Wishbone classic RAM with random wait states and a preload pattern
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module spi_flash_model (
  input  wire  sclk,
  input  wire  cs_n,
  input  wire  mosi,
  output logic miso
);

  localparam int IMAGE_BYTES = 4 * loader_pkg::PAGE_BYTES;
  localparam int BASE = int'(loader_pkg::BOOT_FIRST_PAGE) * loader_pkg::PAGE_BYTES;

  loader_pkg::byte_t image [0:IMAGE_BYTES-1];
  int                next_page = 0;
  int                errors = 0;
  int                bit_n = 0;
  int                dbit = 0;
  int                ptr = 0;
  logic [31:0]       cmd;
  loader_pkg::byte_t sr;

  initial miso = 1'b0;

  // New command on every select
  always @(negedge cs_n) begin
    bit_n = 0;
  end

  // Opcode and address sampled on rising SCLK
  always @(posedge sclk) begin
    if (!cs_n && bit_n < 32) begin
      cmd   = {cmd[30:0], mosi};
      bit_n = bit_n + 1;
      if (bit_n == 32) begin
        if (cmd[31:24] != loader_pkg::FLASH_READ) begin
          $display("Flash model received opcode %h, which is not READ", cmd[31:24]);
          errors++;
        end
        if (int'(cmd[23:0]) != BASE + next_page * loader_pkg::PAGE_BYTES) begin
          $display("Flash model read at %h, but the next page starts at %h",
                   cmd[23:0], BASE + next_page * loader_pkg::PAGE_BYTES);
          errors++;
        end
        next_page++;
        ptr  = int'(cmd[23:0]) - BASE;
        dbit = 0;
      end
    end
  end

  // Data bits change on falling SCLK, MSB first
  always @(negedge sclk) begin
    if (!cs_n && bit_n == 32) begin
      if (dbit == 0) begin
        // Erased flash outside the image
        sr  = (ptr >= 0 && ptr < IMAGE_BYTES) ? image[ptr] : 8'hFF;
        ptr = ptr + 1;
      end
      miso <= sr[7];
      sr   = {sr[6:0], 1'b0};
      dbit = (dbit + 1) % 8;
    end
  end

endmodule

module wb_ram_model (
  input  wire                         clk,
  input  wire                         reset_in,
  input  wire                         cyc,
  input  wire                         stb,
  input  wire                         we,
  input  wire loader_pkg::word_addr_t adr,
  input  wire loader_pkg::data_t      dat_w,
  output loader_pkg::data_t           dat_r,
  output logic                        ack
);

  localparam int WORDS = 1024;

  loader_pkg::data_t mem [0:WORDS-1];
  logic [31:0]       lfsr_state = 32'h10c0_4fa3;
  logic [31:0]       wait_bits;
  int                wait_left = 0;
  logic              in_frame = 1'b0;
  int                errors = 0;

  initial ack = 1'b0;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic preload();
    int i;
    for (i = 0; i < WORDS; i++) begin
      mem[i] = loader_pkg::data_t'(i) ^ 32'hA5A5_0000;
    end
  endtask

  //--------------------------------------------------------------------------
  // Slave side, 0 to 3 wait cycles per frame
  //--------------------------------------------------------------------------
  always @(posedge clk) begin
    if (reset_in) begin
      ack      <= 1'b0;
      in_frame = 1'b0;
    end else if (ack) begin
      ack <= 1'b0;
    end else if (cyc && stb) begin
      if (!in_frame) begin
        take_bits(2, wait_bits);
        wait_left = int'(wait_bits[1:0]);
        in_frame  = 1'b1;
      end
      if (wait_left == 0) begin
        ack      <= 1'b1;
        in_frame = 1'b0;
        if (adr >= WORDS) begin
          $display("RAM model accessed at %h, outside its %0d words", adr, WORDS);
          errors++;
        end else if (we) begin
          mem[adr] <= dat_w;
        end else begin
          dat_r <= mem[adr];
        end
      end else begin
        wait_left--;
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_memory_loader.sv
//--------------------------------------------------------------------------
// Memory loader testbench
// Boots images of several sizes from the flash model, then reads and
// writes the RAM through the host port
//--------------------------------------------------------------------------
`default_nettype none
`timescale 1ns/10ps

module tb_memory_loader;

  // Pages booted over all tests, plus host traffic per test
  localparam int TEST_PAGES   = 3 + 1 + 2 + 1 + 2;
  localparam int TEST_COUNT   = 5;
  localparam int LIMIT_CYCLES = TEST_PAGES * loader_pkg::PAGE_BYTES * 8 * 2 * 2
                                + TEST_COUNT * 4000;
  localparam int IMAGE_BYTES  = 4 * loader_pkg::PAGE_BYTES;

  logic                   clk;
  logic                   reset_in;
  logic                   write_req;
  logic                   read_req;
  loader_pkg::word_addr_t addr;
  loader_pkg::data_t      data_write;
  wire                    boot_done;
  wire loader_pkg::data_t data_read;
  wire                    read_valid;
  wire                    busy;
  wire                    flash_sclk;
  wire                    flash_cs_n;
  wire                    flash_mosi;
  wire                    flash_miso;
  wire                    ram_cyc;
  wire                    ram_stb;
  wire                    ram_we;
  wire loader_pkg::word_addr_t ram_adr;
  wire loader_pkg::data_t ram_dat_w;
  wire loader_pkg::data_t ram_dat_r;
  wire                    ram_ack;

  int                     errors = 0;
  int                     cycles = 0;
  loader_pkg::word_addr_t last_boot_adr;

  memory_loader_top dut (.*);

  spi_flash_model flash (
    .sclk (flash_sclk),
    .cs_n (flash_cs_n),
    .mosi (flash_mosi),
    .miso (flash_miso)
  );

  wb_ram_model ram (
    .clk      (clk),
    .reset_in (reset_in),
    .cyc      (ram_cyc),
    .stb      (ram_stb),
    .we       (ram_we),
    .adr      (ram_adr),
    .dat_w    (ram_dat_w),
    .dat_r    (ram_dat_r),
    .ack      (ram_ack)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > LIMIT_CYCLES) begin
      $display("Run stopped after %0d cycles, the DUT stopped responding", cycles);
      $display("Something failed");
      $finish;
    end
  end

  // Last word written by the boot loader
  always @(negedge clk) begin
    if (ram_cyc && ram_ack && ram_we && !boot_done) begin
      last_boot_adr <= ram_adr;
    end
  end

  //--------------------------------------------------------------------------
  // Checks and expected values
  //--------------------------------------------------------------------------
  task automatic check_data(input string name, input loader_pkg::data_t exp,
                            input loader_pkg::data_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input loader_pkg::word_addr_t exp,
                            input loader_pkg::word_addr_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  // Big-endian word from the flash image
  function automatic loader_pkg::data_t image_word(input int p, input int w);
    int b;
    b = p * loader_pkg::PAGE_BYTES + 4 * w;
    image_word = {flash.image[b], flash.image[b + 1], flash.image[b + 2], flash.image[b + 3]};
  endfunction

  function automatic loader_pkg::data_t preload_word(input int a);
    preload_word = loader_pkg::data_t'(a) ^ 32'hA5A5_0000;
  endfunction

  //--------------------------------------------------------------------------
  // Stimulus helpers
  //--------------------------------------------------------------------------
  task automatic start_test(input loader_pkg::page_count_t count);
    logic [31:0] r;
    int i;
    reset_in = 1'b1;
    for (i = 0; i < IMAGE_BYTES; i++) begin
      ram.take_bits(8, r);
      flash.image[i] = r[7:0];
    end
    // Page count in the low half of word 0
    flash.image[2]  = count[15:8];
    flash.image[3]  = count[7:0];
    flash.next_page = 0;
    ram.preload();
    repeat (4) @(negedge clk);
    reset_in = 1'b0;
  endtask

  task automatic wait_boot();
    while (!boot_done) @(negedge clk);
  endtask

  task automatic collect_read(output loader_pkg::data_t d);
    while (!read_valid) @(negedge clk);
    d = data_read;
    @(negedge clk);
    if (read_valid) begin
      $display("read_valid stayed high for more than one cycle");
      errors++;
    end
  endtask

  task automatic host_read(input int a, output loader_pkg::data_t d);
    while (busy) @(negedge clk);
    read_req = 1'b1;
    addr     = loader_pkg::word_addr_t'(a);
    @(negedge clk);
    read_req = 1'b0;
    if (!busy) begin
      $display("busy did not rise after a read request");
      errors++;
    end
    collect_read(d);
  endtask

  task automatic host_write(input int a, input loader_pkg::data_t d);
    while (busy) @(negedge clk);
    write_req  = 1'b1;
    addr       = loader_pkg::word_addr_t'(a);
    data_write = d;
    @(negedge clk);
    write_req = 1'b0;
    while (busy) @(negedge clk);
    if (read_valid) begin
      $display("read_valid pulsed at the end of a write");
      errors++;
    end
  endtask

  //--------------------------------------------------------------------------
  // Tests
  //--------------------------------------------------------------------------
  task automatic test_boot_copy();
    loader_pkg::data_t d;
    int p;
    int w;
    start_test(16'd3);
    wait_boot();
    check_addr("boot_copy_last_write", loader_pkg::word_addr_t'(3 * 64 - 1), last_boot_adr);
    for (p = 0; p < 3; p++) begin
      for (w = 0; w < loader_pkg::PAGE_WORDS; w++) begin
        host_read(p * loader_pkg::PAGE_WORDS + w, d);
        check_data("boot_copy", image_word(p, w), d);
      end
    end
  endtask

  task automatic test_zero_count();
    loader_pkg::data_t d;
    int w;
    start_test(16'd0);
    wait_boot();
    for (w = 0; w < loader_pkg::PAGE_WORDS; w++) begin
      host_read(w, d);
      check_data("zero_count", image_word(0, w), d);
    end
    host_read(64, d);
    check_data("zero_count_word_64", preload_word(64), d);
  endtask

  task automatic test_busy_during_boot();
    loader_pkg::data_t d;
    int low_seen;
    low_seen = 0;
    start_test(16'd2);
    // Held from the start of the boot
    read_req = 1'b1;
    addr     = 24'd70;
    while (!boot_done) begin
      if (!busy) begin
        low_seen++;
      end
      @(negedge clk);
    end
    if (low_seen != 0) begin
      $display("busy was low in %0d cycles before boot_done", low_seen);
      errors++;
    end
    @(negedge clk);
    read_req = 1'b0;
    collect_read(d);
    check_data("busy_during_boot", image_word(1, 6), d);
  endtask

  task automatic test_write_read();
    logic [31:0] r;
    loader_pkg::data_t d;
    start_test(16'd1);
    wait_boot();
    ram.take_bits(32, r);
    host_write(300, r);
    host_read(300, d);
    check_data("write_read_300", r, d);
    // Overwrite a booted word
    ram.take_bits(32, r);
    host_write(5, r);
    host_read(5, d);
    check_data("write_read_5", r, d);
  endtask

  task automatic test_unloaded_address();
    loader_pkg::data_t d;
    start_test(16'd2);
    wait_boot();
    host_read(127, d);
    check_data("unloaded_last_loaded", image_word(1, 63), d);
    host_read(128, d);
    check_data("unloaded_128", preload_word(128), d);
    host_read(700, d);
    check_data("unloaded_700", preload_word(700), d);
  endtask

  initial begin
    reset_in   = 1'b1;
    write_req  = 1'b0;
    read_req   = 1'b0;
    addr       = '0;
    data_write = '0;
    test_boot_copy();
    test_zero_count();
    test_busy_during_boot();
    test_write_read();
    test_unloaded_address();
    $display("Done: %0d testbench errors, %0d flash model errors, %0d RAM model errors",
             errors, flash.errors, ram.errors);
    if (errors + flash.errors + ram.errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
logic/loader_pkg.sv
logic/wb_if.sv
logic/flash_read_if.sv
logic/spi_flash_reader.sv
logic/boot_loader.sv
logic/host_port.sv
logic/bus_arbiter.sv
logic/memory_loader_top.sv
tests/tb_models.sv
tests/tb_memory_loader.sv

//--- Bender.yml
package:
  name: memory_loader

sources:
  - files:
      - logic/loader_pkg.sv
      - logic/wb_if.sv
      - logic/flash_read_if.sv
      - logic/spi_flash_reader.sv
      - logic/boot_loader.sv
      - logic/host_port.sv
      - logic/bus_arbiter.sv
      - logic/memory_loader_top.sv
  - target: test
    files:
      - tests/tb_models.sv
      - tests/tb_memory_loader.sv
